// File: source/soc_pkg.sv
/*
  Shared widths, address map and bus types for the SoC fabric.
  All windows must be aligned to a 64-bit word and their word counts be powers of two.
  The exit word sits inside main memory and is also a normal storage word.
*/
package soc_pkg;

  // ----------------------------
  // Widths
  // ----------------------------
  localparam int unsigned AddrWidth  = 32;
  localparam int unsigned DataWidth  = 64;
  localparam int unsigned StrbWidth  = DataWidth / 8;
  localparam int unsigned WordOffset = 3;  // Byte bits inside a word

  // ----------------------------
  // Address map
  // ----------------------------
  localparam logic [AddrWidth-1:0] RomBase    = 32'h0001_0000;
  localparam int unsigned          RomWords   = 16;
  localparam logic [AddrWidth-1:0] DramBase   = 32'h8000_0000;
  localparam int unsigned          DramWords  = 1024;
  localparam logic [AddrWidth-1:0] GpioBase   = 32'h4000_0000;
  localparam logic [AddrWidth-1:0] GpioLength = 32'h0000_1000;
  localparam logic [AddrWidth-1:0] ExitAddr   = DramBase + 32'h0000_1000;

  // Word index widths inside each memory
  localparam int unsigned RomIdxWidth  = $clog2(RomWords);
  localparam int unsigned DramIdxWidth = $clog2(DramWords);

  // ----------------------------
  // Reset and debug
  // ----------------------------
  localparam int unsigned RstSyncStages    = 2;
  localparam int unsigned DebugDelayCycles = 40;  // Short window for simulation
  localparam int unsigned DebugCntWidth    = $clog2(DebugDelayCycles + 1);

  // ----------------------------
  // Bus types
  // ----------------------------
  typedef enum logic [1:0] {
    TgtRom,
    TgtDram,
    TgtErr
  } target_e;

  // One-cycle request strobe with payload
  typedef struct packed {
    logic                 req;
    logic                 we;
    logic [AddrWidth-1:0] addr;
    logic [StrbWidth-1:0] be;
    logic [DataWidth-1:0] wdata;
  } mem_req_t;

  typedef struct packed {
    logic                 valid;
    logic                 err;    // Set for GPIO, unmapped or ROM write
    logic [DataWidth-1:0] rdata;
  } mem_rsp_t;

endpackage

// File: source/rst_sync.sv
/*
  Reset generator for the peripherals. Assertion is asynchronous,
  release is synchronous to clk_i. Needs at least two stages.
*/
module rst_sync (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic ndmreset_i,  // Reset request, active high
  output logic rst_no
);

  logic                              rst_comb_n;
  logic [soc_pkg::RstSyncStages-1:0] sync_q;

  // Power-on reset or a non-debug-module reset request
  assign rst_comb_n = rst_ni & ~ndmreset_i;

  always_ff @(posedge clk_i or negedge rst_comb_n) begin
    if (!rst_comb_n) begin
      sync_q <= '0;
    end else begin
      sync_q <= {sync_q[soc_pkg::RstSyncStages-2:0], 1'b1};  // Shift a one through
    end
  end

  assign rst_no = sync_q[soc_pkg::RstSyncStages-1];

endmodule

// File: source/debug_req_gate.sv
/*
  Blocks debug requests for a fixed window after power-on reset,
  so boot code can run before the first halt. Runs on power-on reset
  only; a reset request from the debug side does not reopen the window.
*/
module debug_req_gate (
  input  logic clk_i,
  input  logic rst_ni,          // Power-on reset
  input  logic debug_req_i,
  input  logic debug_enable_i,
  output logic debug_req_o
);

  logic [soc_pkg::DebugCntWidth-1:0] cnt_d;
  logic [soc_pkg::DebugCntWidth-1:0] cnt_q;
  logic                              window_open;

  // ----------------------------
  // Hold-off counter
  // ----------------------------
  assign window_open = (cnt_q == '0);
  assign cnt_d       = window_open ? '0 : cnt_q - 1'b1;  // Stops at zero

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= soc_pkg::DebugCntWidth'(soc_pkg::DebugDelayCycles);
    end else begin
      cnt_q <= cnt_d;
    end
  end

  // Request passes only after the window and when enabled
  assign debug_req_o = window_open & debug_enable_i & debug_req_i;

endmodule

// File: source/bus_decoder.sv
/*
  Address decoder for the single request port. Exactly one request may
  be accepted per cycle and every accepted request is answered one cycle
  later. There is no back-pressure. GPIO, unmapped space and ROM writes
  are answered locally with an error and zero data.
*/
module bus_decoder (
  input  logic                          clk_i,
  input  logic                          rst_ni,        // Peripheral reset
  input  soc_pkg::mem_req_t             mem_req_i,
  output soc_pkg::mem_rsp_t             mem_rsp_o,
  output soc_pkg::mem_req_t             rom_req_o,
  input  logic [soc_pkg::DataWidth-1:0] rom_rdata_i,
  output soc_pkg::mem_req_t             dram_req_o,
  input  logic [soc_pkg::DataWidth-1:0] dram_rdata_i
);

  logic             rom_hit;
  logic             dram_hit;
  logic             gpio_hit;
  soc_pkg::target_e tgt;
  logic             accept;

  logic             en_q;     // Port open
  logic             valid_q;  // Response due this cycle
  soc_pkg::target_e tgt_q;

  // ------------------------------
  // Window decode
  // ------------------------------
  assign rom_hit = (mem_req_i.addr >= soc_pkg::RomBase) &&
                   (mem_req_i.addr < soc_pkg::RomBase + soc_pkg::RomWords * soc_pkg::StrbWidth);

  assign dram_hit = (mem_req_i.addr >= soc_pkg::DramBase) &&
                    (mem_req_i.addr < soc_pkg::DramBase + soc_pkg::DramWords * soc_pkg::StrbWidth);

  assign gpio_hit = (mem_req_i.addr >= soc_pkg::GpioBase) &&
                    (mem_req_i.addr < soc_pkg::GpioBase + soc_pkg::GpioLength);

  always_comb begin
    if (gpio_hit) begin
      tgt = soc_pkg::TgtErr;  // No GPIO block behind this window
    end else if (rom_hit) begin
      tgt = mem_req_i.we ? soc_pkg::TgtErr : soc_pkg::TgtRom;
    end else if (dram_hit) begin
      tgt = soc_pkg::TgtDram;
    end else begin
      tgt = soc_pkg::TgtErr;
    end
  end

  // ------------------------------
  // Request steering
  // ------------------------------
  assign accept = mem_req_i.req & en_q;

  always_comb begin
    rom_req_o      = mem_req_i;
    rom_req_o.req  = accept && (tgt == soc_pkg::TgtRom);
    dram_req_o     = mem_req_i;
    dram_req_o.req = accept && (tgt == soc_pkg::TgtDram);
  end

  // Port opens one cycle after the peripheral reset lifts
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      en_q    <= 1'b0;
      valid_q <= 1'b0;
      tgt_q   <= soc_pkg::TgtErr;
    end else begin
      en_q    <= 1'b1;
      valid_q <= accept;
      if (accept) begin
        tgt_q <= tgt;
      end
    end
  end

  // ------------------------------
  // Response mux
  // ------------------------------
  always_comb begin
    mem_rsp_o       = '0;
    mem_rsp_o.valid = valid_q;
    case (tgt_q)
      soc_pkg::TgtRom:  mem_rsp_o.rdata = rom_rdata_i;
      soc_pkg::TgtDram: mem_rsp_o.rdata = dram_rdata_i;
      default:          mem_rsp_o.err   = valid_q;  // Data stays zero
    endcase
  end

endmodule

// File: source/boot_rom.sv
/*
  Boot ROM of RomWords 64-bit words with a registered read.
  Content comes from source/boot_rom.hex, relative to the run directory.
  Addresses wrap modulo RomWords; writes never reach this block.
*/
module boot_rom (
  input  logic                          clk_i,
  input  soc_pkg::mem_req_t             req_i,
  output logic [soc_pkg::DataWidth-1:0] rdata_o
);

  logic [soc_pkg::DataWidth-1:0]   rom_q [soc_pkg::RomWords];
  logic [soc_pkg::RomIdxWidth-1:0] idx;
  logic [soc_pkg::DataWidth-1:0]   rdata_q;

  initial begin
    $readmemh("source/boot_rom.hex", rom_q);
  end

  // Word index above the byte offset
  assign idx = req_i.addr[soc_pkg::WordOffset +: soc_pkg::RomIdxWidth];

  always_ff @(posedge clk_i) begin
    if (req_i.req) begin
      rdata_q <= rom_q[idx];
    end
  end

  assign rdata_o = rdata_q;  // Held until the next strobe

endmodule

// File: source/main_mem.sv
/*
  Main memory of DramWords 64-bit words, zero at start, byte-enabled
  writes and registered read. A write returns the old word. The exit
  word is watched on the request strobe, not on stored content.
*/
module main_mem (
  input  logic                          clk_i,
  input  soc_pkg::mem_req_t             req_i,
  output logic [soc_pkg::DataWidth-1:0] rdata_o,
  output logic [soc_pkg::DataWidth-1:0] exit_o
);

  logic [soc_pkg::DataWidth-1:0]    mem_q [soc_pkg::DramWords];
  logic [soc_pkg::DramIdxWidth-1:0] idx;
  logic [soc_pkg::DataWidth-1:0]    rdata_q;
  logic                             exit_hit;

  initial begin
    for (int i = 0; i < soc_pkg::DramWords; i++) begin
      mem_q[i] = '0;
    end
  end

  assign idx = req_i.addr[soc_pkg::WordOffset +: soc_pkg::DramIdxWidth];

  // ----------------------------
  // Storage
  // ----------------------------
  always_ff @(posedge clk_i) begin
    if (req_i.req) begin
      rdata_q <= mem_q[idx];  // Old word, also on writes
      if (req_i.we) begin
        for (int b = 0; b < soc_pkg::StrbWidth; b++) begin
          if (req_i.be[b]) begin
            mem_q[idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
          end
        end
      end
    end
  end

  assign rdata_o = rdata_q;

  // ----------------------------
  // Exit word
  // ----------------------------
  // Visible only in the cycle of the write strobe
  assign exit_hit = req_i.req & req_i.we & (req_i.addr == soc_pkg::ExitAddr);
  assign exit_o   = exit_hit ? req_i.wdata : '0;

endmodule

// File: source/soc_top.sv
/*
  Memory fabric of the SoC with one request port standing in for the core.
  Responses arrive one cycle after a request, with no back-pressure.
  The debug gate runs on power-on reset, the fabric on the peripheral reset.
*/
module soc_top (
  input  logic                          clk_i,
  input  logic                          rst_ni,          // Power-on reset
  input  logic                          ndmreset_i,      // Reset request from debug side
  input  logic                          debug_req_i,
  input  logic                          debug_enable_i,
  input  soc_pkg::mem_req_t             mem_req_i,
  output soc_pkg::mem_rsp_t             mem_rsp_o,
  output logic                          debug_req_o,
  output logic [soc_pkg::DataWidth-1:0] exit_o
);

  logic                          periph_rst_n;
  soc_pkg::mem_req_t             rom_req;
  soc_pkg::mem_req_t             dram_req;
  logic [soc_pkg::DataWidth-1:0] rom_rdata;
  logic [soc_pkg::DataWidth-1:0] dram_rdata;

  // ------------------------------
  // Reset and debug
  // ------------------------------
  rst_sync rst_sync_inst (
    .clk_i      ( clk_i        ),
    .rst_ni     ( rst_ni       ),
    .ndmreset_i ( ndmreset_i   ),
    .rst_no     ( periph_rst_n )
  );

  debug_req_gate debug_req_gate_inst (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .debug_req_i    ( debug_req_i    ),
    .debug_enable_i ( debug_enable_i ),
    .debug_req_o    ( debug_req_o    )
  );

  // ------------------------------
  // Fabric
  // ------------------------------
  bus_decoder bus_decoder_inst (
    .clk_i        ( clk_i        ),
    .rst_ni       ( periph_rst_n ),
    .mem_req_i    ( mem_req_i    ),
    .mem_rsp_o    ( mem_rsp_o    ),
    .rom_req_o    ( rom_req      ),
    .rom_rdata_i  ( rom_rdata    ),
    .dram_req_o   ( dram_req     ),
    .dram_rdata_i ( dram_rdata   )
  );

  boot_rom boot_rom_inst (
    .clk_i   ( clk_i     ),
    .req_i   ( rom_req   ),
    .rdata_o ( rom_rdata )
  );

  // Exit word taken from the memory side of the decoder
  main_mem main_mem_inst (
    .clk_i   ( clk_i      ),
    .req_i   ( dram_req   ),
    .rdata_o ( dram_rdata ),
    .exit_o  ( exit_o     )
  );

endmodule

// File: testbench/tb_clock_gen.sv
/*
  Clock and power-on reset for the testbench.
  100 ns period, reset low for the first 16 rising edges.
*/
module tb_clock_gen (
  output logic clk_o,
  output logic rst_no
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int ResetCycles = 16;

  initial begin
    clk_o = 1'b0;
    forever #50 clk_o = ~clk_o;
  end

  initial begin
    rst_no = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    #10 rst_no = 1'b1;  // Same offset as the other inputs
  end

endmodule

// File: testbench/tb_soc_top.sv
/*
  Testbench for soc_top, standing in for the core on the request port.
  Run from the project root so the ROM image path resolves.
  Stimulus comes from a Galois LFSR with a fixed seed.
*/
module tb_soc_top;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int PorCycles  = 16;
  localparam int IdleCycles = 8;
  localparam int RomReads   = 40;
  localparam int DramOps    = 200;
  localparam int ErrOps     = 60;
  localparam int ExitOps    = 20;
  localparam int NdmCycles  = 6;
  localparam int DramWindow = 32;  // Words hit by random DRAM traffic
  localparam int ReadBack   = DramWindow + 1;
  localparam int TimeoutCycles = PorCycles + 2 * IdleCycles + RomReads + DramOps + ErrOps +
                                 (ExitOps + 1) + NdmCycles + soc_pkg::RstSyncStages +
                                 (2 * ReadBack + 1) + 200;

  logic                          clk;
  logic                          rst_n;
  logic                          ndmreset;
  logic                          ndm_next;  // Applied with the next drive
  logic                          debug_req;
  logic                          debug_enable;
  logic                          debug_req_out;
  soc_pkg::mem_req_t             mem_req;
  soc_pkg::mem_rsp_t             mem_rsp;
  logic [soc_pkg::DataWidth-1:0] exit_word;

  logic [31:0]                   lfsr_state;
  logic [soc_pkg::DataWidth-1:0] rom_model  [soc_pkg::RomWords];
  logic [soc_pkg::DataWidth-1:0] dram_model [soc_pkg::DramWords];
  soc_pkg::mem_rsp_t             exp_rsp_q  [$];
  int                            errors;
  int                            checks;
  int                            cycle_count = 0;
  int                            edges_since_por = 0;

  tb_clock_gen tb_clock_gen_inst (
    .clk_o  ( clk   ),
    .rst_no ( rst_n )
  );

  soc_top soc_top_inst (
    .clk_i          ( clk           ),
    .rst_ni         ( rst_n         ),
    .ndmreset_i     ( ndmreset      ),
    .debug_req_i    ( debug_req     ),
    .debug_enable_i ( debug_enable  ),
    .mem_req_i      ( mem_req       ),
    .mem_rsp_o      ( mem_rsp       ),
    .debug_req_o    ( debug_req_out ),
    .exit_o         ( exit_word     )
  );

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (rst_n) begin
      edges_since_por <= edges_since_por + 1;  // Debug hold-off reference
    end
    if (cycle_count >= TimeoutCycles) begin
      $display("Timeout: test did not finish within %0d cycles", cycle_count);
      $display("** FAIL **");
      $finish;
    end
  end

  // ------------------------------
  // Random numbers
  // ------------------------------
  // Galois form, right shift, taps 32 30 26 25
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
  endfunction

  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      r = {r[62:0], lfsr_state[0]};
    end
    return r;
  endfunction

  // ------------------------------
  // Request builders
  // ------------------------------
  function automatic soc_pkg::mem_req_t make_req(input logic we, input logic [31:0] addr,
                                                 input logic [7:0] be, input logic [63:0] wdata);
    soc_pkg::mem_req_t r;
    r.req   = 1'b1;
    r.we    = we;
    r.addr  = addr;
    r.be    = be;
    r.wdata = wdata;
    return r;
  endfunction

  function automatic soc_pkg::mem_req_t dram_req_rand();
    logic        we;
    logic [31:0] addr;
    we   = rand_bits(1) != 0;
    addr = soc_pkg::DramBase + 32'(rand_bits(5)) * 8 + 32'(rand_bits(3));
    return make_req(we, addr, 8'(rand_bits(8)), rand_bits(64));
  endfunction

  function automatic soc_pkg::mem_req_t error_req();
    logic [1:0]  kind;
    logic        we;
    logic [31:0] addr;
    kind = 2'(rand_bits(2));
    we   = rand_bits(1) != 0;
    case (kind)
      2'd0: begin
        addr = soc_pkg::RomBase + 32'(rand_bits(7));
        we   = 1'b1;  // ROM write
      end
      2'd1:    addr = soc_pkg::GpioBase + 32'(rand_bits(12));
      2'd2:    addr = 32'h2000_0000 + 32'(rand_bits(24));  // Unmapped
      default: addr = soc_pkg::DramBase + 32'h2000 + 32'(rand_bits(12));  // Past DRAM end
    endcase
    return make_req(we, addr, 8'(rand_bits(8)), rand_bits(64));
  endfunction

  // ------------------------------
  // Reference model
  // ------------------------------
  function automatic soc_pkg::target_e expected_target(input logic [31:0] addr,
                                                       input logic we);
    logic in_rom;
    logic in_dram;
    logic in_gpio;
    in_rom  = addr >= soc_pkg::RomBase &&
              addr < soc_pkg::RomBase + (soc_pkg::RomWords << soc_pkg::WordOffset);
    in_dram = addr >= soc_pkg::DramBase &&
              addr < soc_pkg::DramBase + (soc_pkg::DramWords << soc_pkg::WordOffset);
    in_gpio = addr >= soc_pkg::GpioBase && addr < soc_pkg::GpioBase + soc_pkg::GpioLength;
    if (in_rom && !we) return soc_pkg::TgtRom;
    if (in_dram) return soc_pkg::TgtDram;
    return soc_pkg::TgtErr;  // GPIO, ROM write or unmapped
  endfunction

  task automatic model_request(input soc_pkg::mem_req_t req, input logic accepted);
    soc_pkg::mem_rsp_t exp;
    soc_pkg::target_e  tgt;
    int                idx;
    exp = '0;
    if (req.req && accepted) begin
      exp.valid = 1'b1;
      tgt = expected_target(req.addr, req.we);
      if (tgt == soc_pkg::TgtRom) begin
        idx = int'((req.addr - soc_pkg::RomBase) >> soc_pkg::WordOffset);
        exp.rdata = rom_model[idx];
      end else if (tgt == soc_pkg::TgtDram) begin
        idx = int'((req.addr - soc_pkg::DramBase) >> soc_pkg::WordOffset);
        exp.rdata = dram_model[idx];  // Old word on writes too
        for (int b = 0; b < soc_pkg::StrbWidth; b++) begin
          if (req.we && req.be[b]) begin
            dram_model[idx][8*b +: 8] = req.wdata[8*b +: 8];
          end
        end
      end else begin
        exp.err = 1'b1;
      end
    end
    exp_rsp_q.push_back(exp);
  endtask

  task automatic check_response();
    soc_pkg::mem_rsp_t exp;
    if (exp_rsp_q.size() > 0) begin
      exp = exp_rsp_q.pop_front();
      checks++;
      if (mem_rsp.valid !== exp.valid) begin
        errors++;
        $display("Error at %0t ns: response valid %b, expected %b", $time, mem_rsp.valid,
                 exp.valid);
      end else if (exp.valid && (mem_rsp.err !== exp.err || mem_rsp.rdata !== exp.rdata)) begin
        errors++;
        $display("Error at %0t ns: response err %b data %h, expected err %b data %h", $time,
                 mem_rsp.err, mem_rsp.rdata, exp.err, exp.rdata);
      end
    end
  endtask

  // Checks the last response, drives new inputs and checks combinational outputs
  task automatic drive_cycle(input soc_pkg::mem_req_t req, input logic accepted);
    logic [1:0]                    rnd;
    logic [soc_pkg::DataWidth-1:0] exp_exit;
    logic                          exp_debug;
    @(posedge clk);
    #10;
    check_response();
    rnd          = 2'(rand_bits(2));
    mem_req      = req;
    ndmreset     = ndm_next;
    debug_req    = rnd[0];
    debug_enable = rnd[1];
    #1;
    exp_exit  = (accepted && req.req && req.we && req.addr == soc_pkg::ExitAddr) ?
                req.wdata : '0;
    exp_debug = (edges_since_por >= soc_pkg::DebugDelayCycles) && debug_req && debug_enable;
    checks += 2;
    if (exit_word !== exp_exit) begin
      errors++;
      $display("Error at %0t ns: exit_o %h, expected %h", $time, exit_word, exp_exit);
    end
    if (debug_req_out !== exp_debug) begin
      errors++;
      $display("Error at %0t ns: debug_req_o %b, expected %b", $time, debug_req_out, exp_debug);
    end
    model_request(req, accepted);
  endtask

  task automatic read_back_dram();
    for (int i = 0; i < DramWindow; i++) begin
      drive_cycle(make_req(1'b0, soc_pkg::DramBase + 32'(i) * 8, '0, '0), 1'b1);
    end
    drive_cycle(make_req(1'b0, soc_pkg::ExitAddr, '0, '0), 1'b1);
  endtask

  // ------------------------------
  // Test sequence
  // ------------------------------
  initial begin
    logic [1:0] sel;
    errors       = 0;
    checks       = 0;
    lfsr_state   = 32'h4969;
    mem_req      = '0;
    ndmreset     = 1'b0;
    ndm_next     = 1'b0;
    debug_req    = 1'b0;
    debug_enable = 1'b0;
    for (int i = 0; i < soc_pkg::DramWords; i++) begin
      dram_model[i] = '0;
    end
    $readmemh("source/boot_rom.hex", rom_model);

    while (rst_n !== 1'b1) drive_cycle('0, 1'b0);  // Debug inputs already random
    repeat (IdleCycles) drive_cycle('0, 1'b0);

    repeat (RomReads) begin
      drive_cycle(make_req(1'b0, soc_pkg::RomBase + 32'(rand_bits(7)), '0, '0), 1'b1);
    end
    repeat (DramOps) drive_cycle(dram_req_rand(), 1'b1);  // Back to back
    repeat (ErrOps) drive_cycle(error_req(), 1'b1);
    read_back_dram();

    // Exit word
    drive_cycle(make_req(1'b1, soc_pkg::ExitAddr, 8'hff, rand_bits(64)), 1'b1);
    repeat (ExitOps) begin
      sel = 2'(rand_bits(2));
      if (sel[1] == 1'b0) begin
        drive_cycle(make_req(1'b1, soc_pkg::ExitAddr, 8'(rand_bits(8)), rand_bits(64)), 1'b1);
      end else if (sel[0]) begin
        drive_cycle(make_req(1'b0, soc_pkg::ExitAddr, '0, '0), 1'b1);
      end else begin
        drive_cycle(dram_req_rand(), 1'b1);
      end
    end

    // Reset request with traffic still running
    ndm_next = 1'b1;
    repeat (NdmCycles) drive_cycle(dram_req_rand(), 1'b0);
    ndm_next = 1'b0;
    repeat (soc_pkg::RstSyncStages) drive_cycle(dram_req_rand(), 1'b0);
    repeat (IdleCycles) drive_cycle('0, 1'b0);
    read_back_dram();
    drive_cycle('0, 1'b0);  // Drain the last response

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// File: source/boot_rom.hex
// Boot ROM image: one 64-bit word per line in hex, word 0 first
0010029300000297
00a2b02300004317
0002b30300830313
fe031ee300128293
0000006f00000013
1234567800c0ffee
deadbeef0badf00d
a5a5a5a55a5a5a5a
0123456789abcdef
fedcba9876543210
00000000ffffffff
ffffffff00000000
8000000000000001
7ffffffffffffffe
3c3c3c3cc3c3c3c3
0f0f0f0ff0f0f0f0

// File: mini_soc.f
source/soc_pkg.sv
source/rst_sync.sv
source/debug_req_gate.sv
source/bus_decoder.sv
source/boot_rom.sv
source/main_mem.sv
source/soc_top.sv
testbench/tb_clock_gen.sv
testbench/tb_soc_top.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the mini_soc testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --timescale 1ns/1ps \
  --top-module tb_soc_top -f mini_soc.f -o sim_tb_soc_top

out=$(./obj_dir/sim_tb_soc_top)
echo "$out"

if echo "$out" | grep -qF '** PASS **'; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed"
  exit 1
fi
